//--- compile.f
hw/lb_pkg.sv
hw/gps_edge_counter.sv
hw/lb_reg_bank.sv
hw/lb_host.sv
hw/lb_base_core.sv
hw/lb_base_shell.sv
test/lb_base_checker.sv
test/lb_base_tb.sv

//--- hw/gps_edge_counter.sv
// GPS edge counter
// Counts low-to-high transitions on one GPS line
`timescale 1ns/1ps

module gps_edge_counter (
	input  logic                          lb_clk,
	input  logic                          arst_n,
	input  logic                          gps_line,
	output logic [lb_pkg::LB_DATA_W-1:0]  count
);

	// Level seen on the previous edge
	logic gps_prev;
	logic rise;

	assign rise = gps_line & ~gps_prev;

	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			gps_prev <= 1'b0;
			count    <= '0;
		end else begin
			gps_prev <= gps_line;
			// Wraps at full scale
			if (rise)
				count <= count + 1'b1;
		end
	end

endmodule

//--- hw/lb_base_core.sv
// Local-bus base core
// Joins bus host, register bank and GPS counter, picks the read source
`timescale 1ns/1ps

module lb_base_core (
	input  logic                          lb_clk,
	input  logic                          arst_n,
	input  logic                          cmd_strobe,
	input  logic                          cmd_rd,
	input  logic [lb_pkg::LB_ADDR_W-1:0]  cmd_addr,
	input  logic [lb_pkg::LB_DATA_W-1:0]  cmd_data,
	input  logic [lb_pkg::GPS_W-1:0]      gps_r,
	input  logic [lb_pkg::LB_DATA_W-1:0]  lb_data_in_r,
	output logic [lb_pkg::LB_ADDR_W-1:0]  lb_addr_w,
	output logic                          lb_strobe_w,
	output logic                          lb_rd_w,
	output logic                          lb_write_w,
	output logic                          lb_rd_valid_w,
	output logic [lb_pkg::LB_DATA_W-1:0]  lb_data_out_w
);

	// Read return path
	logic [lb_pkg::LB_ADDR_W-1:0] rd_addr_late;
	logic                         rd_internal_late;
	logic [lb_pkg::LB_DATA_W-1:0] bank_rd_data;
	logic [lb_pkg::LB_DATA_W-1:0] rd_data;
	logic [lb_pkg::LB_DATA_W-1:0] gps_count;
	// Write data for the bank, kept apart from the shared data lines
	logic [lb_pkg::LB_DATA_W-1:0] wr_data_r;

	lb_host host (
		.lb_clk           (lb_clk),
		.arst_n           (arst_n),
		.cmd_strobe       (cmd_strobe),
		.cmd_rd           (cmd_rd),
		.cmd_addr         (cmd_addr),
		.cmd_data         (cmd_data),
		.rd_data          (rd_data),
		.lb_addr          (lb_addr_w),
		.lb_strobe        (lb_strobe_w),
		.lb_rd            (lb_rd_w),
		.lb_write         (lb_write_w),
		.lb_data_out      (lb_data_out_w),
		.lb_rd_valid      (lb_rd_valid_w),
		.rd_addr_late     (rd_addr_late),
		.rd_internal_late (rd_internal_late)
	);

	// A read return may own lb_data_out_w on a write edge
	// Same edge as the host's bus registers
	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n)
			wr_data_r <= '0;
		else if (cmd_strobe && !cmd_rd)
			wr_data_r <= cmd_data;
	end

	// Bank sees every bus write, internal or not, and decodes it itself
	lb_reg_bank bank (
		.lb_clk    (lb_clk),
		.arst_n    (arst_n),
		.wr_strobe (lb_strobe_w & lb_write_w),
		.wr_addr   (lb_addr_w),
		.wr_data   (wr_data_r),
		.rd_addr   (rd_addr_late),
		.gps_count (gps_count),
		.gps_level (gps_r),
		.rd_data   (bank_rd_data)
	);

	gps_edge_counter gps_cnt (
		.lb_clk   (lb_clk),
		.arst_n   (arst_n),
		.gps_line (gps_r[0]),
		.count    (gps_count)
	);

	// Source flag rides the pipeline with the address
	assign rd_data = rd_internal_late ? bank_rd_data : lb_data_in_r;

endmodule

//--- hw/lb_base_shell.sv
// Local-bus base shell
// Puts one flip-flop on every signal crossing the boundary of the core
`timescale 1ns/1ps

module lb_base_shell (
	input  logic                          lb_clk,
	input  logic                          arst_n,
	// Command port
	input  logic                          cmd_strobe,
	input  logic                          cmd_rd,
	input  logic [lb_pkg::LB_ADDR_W-1:0]  cmd_addr,
	input  logic [lb_pkg::LB_DATA_W-1:0]  cmd_data,
	// GPS lines
	input  logic [lb_pkg::GPS_W-1:0]      gps,
	// Local bus to the external application
	input  logic [lb_pkg::LB_DATA_W-1:0]  lb_data_in,
	output logic [lb_pkg::LB_ADDR_W-1:0]  lb_addr,
	output logic                          lb_strobe,
	output logic                          lb_rd,
	output logic                          lb_write,
	output logic                          lb_rd_valid,
	output logic [lb_pkg::LB_DATA_W-1:0]  lb_data_out
);

	// Bus outputs straight from the core
	logic [lb_pkg::LB_ADDR_W-1:0] lb_addr_w;
	logic                         lb_strobe_w;
	logic                         lb_rd_w;
	logic                         lb_write_w;
	logic                         lb_rd_valid_w;
	logic [lb_pkg::LB_DATA_W-1:0] lb_data_out_w;

	// Registered inputs toward the core
	logic [lb_pkg::LB_DATA_W-1:0] lb_data_in_r;
	logic [lb_pkg::GPS_W-1:0]     gps_r;

	// Outgoing bus stage
	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			lb_addr     <= '0;
			lb_strobe   <= 1'b0;
			lb_rd       <= 1'b0;
			lb_write    <= 1'b0;
			lb_rd_valid <= 1'b0;
			lb_data_out <= '0;
		end else begin
			lb_addr     <= lb_addr_w;
			lb_strobe   <= lb_strobe_w;
			lb_rd       <= lb_rd_w;
			lb_write    <= lb_write_w;
			lb_rd_valid <= lb_rd_valid_w;
			lb_data_out <= lb_data_out_w;
		end
	end

	// Incoming stage
	// Application answer lands here one edge after the top address
	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			lb_data_in_r <= '0;
			gps_r        <= '0;
		end else begin
			lb_data_in_r <= lb_data_in;
			gps_r        <= gps;
		end
	end

	lb_base_core core (
		.lb_clk        (lb_clk),
		.arst_n        (arst_n),
		.cmd_strobe    (cmd_strobe),
		.cmd_rd        (cmd_rd),
		.cmd_addr      (cmd_addr),
		.cmd_data      (cmd_data),
		.gps_r         (gps_r),
		.lb_data_in_r  (lb_data_in_r),
		.lb_addr_w     (lb_addr_w),
		.lb_strobe_w   (lb_strobe_w),
		.lb_rd_w       (lb_rd_w),
		.lb_write_w    (lb_write_w),
		.lb_rd_valid_w (lb_rd_valid_w),
		.lb_data_out_w (lb_data_out_w)
	);

endmodule

//--- hw/lb_host.sv
// Local-bus host
// Drives command pulses onto the bus and runs the read return pipeline
`timescale 1ns/1ps

module lb_host (
	input  logic                          lb_clk,
	input  logic                          arst_n,
	input  logic                          cmd_strobe,
	input  logic                          cmd_rd,
	input  logic [lb_pkg::LB_ADDR_W-1:0]  cmd_addr,
	input  logic [lb_pkg::LB_DATA_W-1:0]  cmd_data,
	input  logic [lb_pkg::LB_DATA_W-1:0]  rd_data,
	output logic [lb_pkg::LB_ADDR_W-1:0]  lb_addr,
	output logic                          lb_strobe,
	output logic                          lb_rd,
	output logic                          lb_write,
	output logic [lb_pkg::LB_DATA_W-1:0]  lb_data_out,
	output logic                          lb_rd_valid,
	output logic [lb_pkg::LB_ADDR_W-1:0]  rd_addr_late,
	output logic                          rd_internal_late
);

	localparam int LAST = lb_pkg::READ_PIPE_LEN - 1;

	// Read pipeline whose stage 0 loads on the command edge
	logic [lb_pkg::READ_PIPE_LEN-1:0] rd_vld;
	logic [lb_pkg::LB_ADDR_W-1:0]     rd_addr_pipe [lb_pkg::READ_PIPE_LEN];
	logic [lb_pkg::READ_PIPE_LEN-1:0] rd_int_pipe;
	logic                             cmd_read;
	logic                             cmd_write;

	assign cmd_read  = cmd_strobe & cmd_rd;
	assign cmd_write = cmd_strobe & ~cmd_rd;

	// Bus controls pulse once per command
	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n) begin
			lb_strobe   <= 1'b0;
			lb_rd       <= 1'b0;
			lb_write    <= 1'b0;
			lb_addr     <= '0;
			lb_data_out <= '0;
			lb_rd_valid <= 1'b0;
			rd_vld      <= '0;
		end else begin
			lb_strobe   <= cmd_strobe;
			lb_rd       <= cmd_read;
			lb_write    <= cmd_write;
			if (cmd_strobe)
				lb_addr <= cmd_addr;
			// Read return takes the data lines over a write landing on the same edge
			if (rd_vld[LAST])
				lb_data_out <= rd_data;
			else if (cmd_write)
				lb_data_out <= cmd_data;
			lb_rd_valid <= rd_vld[LAST];
			rd_vld      <= {rd_vld[LAST-1:0], cmd_read};
		end
	end

	// Address and source flag of each read in flight
	always_ff @(posedge lb_clk) begin
		rd_addr_pipe[0] <= cmd_addr;
		rd_int_pipe[0]  <= cmd_addr < lb_pkg::INT_SPACE_TOP;
		for (int i = 1; i < lb_pkg::READ_PIPE_LEN; i++) begin
			rd_addr_pipe[i] <= rd_addr_pipe[i-1];
			rd_int_pipe[i]  <= rd_int_pipe[i-1];
		end
	end

	// Data is picked from the last stage and captured on the next edge
	assign rd_addr_late     = rd_addr_pipe[LAST];
	assign rd_internal_late = rd_int_pipe[LAST];

endmodule

//--- hw/lb_pkg.sv
// Local-bus base package
// Bus widths, internal register map and read pipeline length
package lb_pkg;

	// Local bus geometry
	localparam int LB_ADDR_W = 24;
	localparam int LB_DATA_W = 32;

	// Number of GPS input lines
	localparam int GPS_W = 4;

	// Cycles from an internal read strobe to rd_valid at the core
	// Outgoing address reg, incoming data reg, core capture reg
	localparam int READ_PIPE_LEN = 3;

	// First address handed to the external application
	localparam logic [LB_ADDR_W-1:0] INT_SPACE_TOP = 24'h000010;

	// Internal register map
	localparam logic [LB_ADDR_W-1:0] REG_ID        = 24'h000000;
	localparam logic [LB_ADDR_W-1:0] REG_SCRATCH   = 24'h000001;
	localparam logic [LB_ADDR_W-1:0] REG_GPS_COUNT = 24'h000002;
	localparam logic [LB_ADDR_W-1:0] REG_GPS_LEVEL = 24'h000003;

	// Identity word returned at REG_ID
	localparam logic [LB_DATA_W-1:0] ID_WORD = 32'h1b5e_0a01;

endpackage

//--- hw/lb_reg_bank.sv
// Internal register bank
// Identity, scratch, GPS edge count and GPS levels at the bottom of the map
`timescale 1ns/1ps

module lb_reg_bank (
	input  logic                          lb_clk,
	input  logic                          arst_n,
	// Write side from the host's bus cycle
	input  logic                          wr_strobe,
	input  logic [lb_pkg::LB_ADDR_W-1:0]  wr_addr,
	input  logic [lb_pkg::LB_DATA_W-1:0]  wr_data,
	// Read side at the address leaving the read pipeline
	input  logic [lb_pkg::LB_ADDR_W-1:0]  rd_addr,
	// Status sources
	input  logic [lb_pkg::LB_DATA_W-1:0]  gps_count,
	input  logic [lb_pkg::GPS_W-1:0]      gps_level,
	output logic [lb_pkg::LB_DATA_W-1:0]  rd_data
);

	logic [lb_pkg::LB_DATA_W-1:0] scratch;
	logic                         wr_internal;
	logic                         rd_internal;

	// Only the internal window is decoded
	assign wr_internal = wr_addr < lb_pkg::INT_SPACE_TOP;
	assign rd_internal = rd_addr < lb_pkg::INT_SPACE_TOP;

	// Scratch register
	// Other internal addresses are read-only and ignore writes
	always_ff @(posedge lb_clk or negedge arst_n) begin
		if (!arst_n)
			scratch <= '0;
		else if (wr_strobe && wr_internal && wr_addr == lb_pkg::REG_SCRATCH)
			scratch <= wr_data;
	end

	// Read decode
	always_comb begin
		rd_data = '0;
		if (rd_internal) begin
			case (rd_addr)
				lb_pkg::REG_ID:
					rd_data = lb_pkg::ID_WORD;
				lb_pkg::REG_SCRATCH:
					rd_data = scratch;
				lb_pkg::REG_GPS_COUNT:
					rd_data = gps_count;
				lb_pkg::REG_GPS_LEVEL:
					// Levels sit in the low bits
					rd_data = {{(lb_pkg::LB_DATA_W - lb_pkg::GPS_W){1'b0}}, gps_level};
				default:
					// Unused internal slots read as zero
					rd_data = '0;
			endcase
		end
	end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the local-bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module lb_base_tb -o sim_lb_base
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_lb_base > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

//--- test/lb_base_checker.sv
// Local-bus checker
// Predicts bus cycles and read data from the command port and compares DUT outputs
`timescale 1ns/1ps

module lb_base_checker #(
	parameter logic [31:0] APP_PATTERN = 32'h0
) (
	input  logic                          lb_clk,
	input  logic                          arst_n,
	input  logic                          cmd_strobe,
	input  logic                          cmd_rd,
	input  logic [lb_pkg::LB_ADDR_W-1:0]  cmd_addr,
	input  logic [lb_pkg::LB_DATA_W-1:0]  cmd_data,
	input  logic [lb_pkg::GPS_W-1:0]      gps,
	// Table value for reads whose result is known up front
	input  logic                          exp_en,
	input  logic [lb_pkg::LB_DATA_W-1:0]  exp_data,
	input  logic [lb_pkg::LB_ADDR_W-1:0]  lb_addr,
	input  logic                          lb_strobe,
	input  logic                          lb_rd,
	input  logic                          lb_write,
	input  logic                          lb_rd_valid,
	input  logic [lb_pkg::LB_DATA_W-1:0]  lb_data_out,
	output int                            err_count,
	output int                            outstanding
);

	int                           cyc;
	logic                         started;
	// Commands seen one and two edges ago
	logic                         h1_stb, h1_rd, h2_stb, h2_rd;
	logic [lb_pkg::LB_ADDR_W-1:0] h1_addr, h2_addr;
	logic [lb_pkg::LB_DATA_W-1:0] h1_data, h2_data;
	// Own copy of bank state
	logic [lb_pkg::LB_DATA_W-1:0] scratch_m;
	logic [lb_pkg::LB_DATA_W-1:0] count_m;
	logic                         gps0_prev;
	// Reads waiting for their decode edge and then for lb_rd_valid
	logic [lb_pkg::LB_ADDR_W-1:0] pend_addr[$];
	int                           pend_cyc[$];
	logic                         pend_ee[$];
	logic [lb_pkg::LB_DATA_W-1:0] pend_exp[$];
	logic [lb_pkg::LB_DATA_W-1:0] exp_q[$];
	int                           exp_due[$];

	initial begin
		err_count   = 0;
		outstanding = 0;
	end

	// Read value at the decode edge of a read
	function automatic logic [31:0] predict_read(input logic [23:0] addr);
		if (addr >= lb_pkg::INT_SPACE_TOP)
			return {8'h00, addr} ^ APP_PATTERN;
		if (addr == lb_pkg::REG_ID)
			return lb_pkg::ID_WORD;
		if (addr == lb_pkg::REG_SCRATCH)
			return scratch_m;
		if (addr == lb_pkg::REG_GPS_COUNT)
			return count_m;
		if (addr == lb_pkg::REG_GPS_LEVEL)
			return {28'h0, gps};
		return 32'h0;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		$display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
		err_count++;
	endtask

	always @(posedge lb_clk) begin
		logic [31:0] exp_val;
		int          due;
		if (!arst_n) begin
			cyc = 0;
			started = 0;
			{h1_stb, h1_rd, h2_stb, h2_rd} = '0;
			{h1_addr, h2_addr, h1_data, h2_data} = '0;
			scratch_m = '0;
			count_m = '0;
			gps0_prev = 0;
			pend_addr.delete();
			pend_cyc.delete();
			pend_ee.delete();
			pend_exp.delete();
			exp_q.delete();
			exp_due.delete();
		end else begin
			// Top bus shows the command sampled two edges ago
			if (h2_stb)
				started = 1;
			if (lb_strobe !== h2_stb)
				report_mismatch("lb_strobe", {31'h0, h2_stb}, {31'h0, lb_strobe});
			if (lb_rd !== (h2_stb & h2_rd))
				report_mismatch("lb_rd", {31'h0, h2_stb & h2_rd}, {31'h0, lb_rd});
			if (lb_write !== (h2_stb & ~h2_rd))
				report_mismatch("lb_write", {31'h0, h2_stb & ~h2_rd}, {31'h0, lb_write});
			if (h2_stb && lb_addr !== h2_addr)
				report_mismatch("lb_addr", {8'h0, h2_addr}, {8'h0, lb_addr});
			else if (!started && lb_addr !== '0)
				report_mismatch("lb_addr", 32'h0, {8'h0, lb_addr});
			// A read return owns the data lines in its cycle
			if (h2_stb && !h2_rd && !lb_rd_valid && lb_data_out !== h2_data)
				report_mismatch("lb_data_out", h2_data, lb_data_out);
			else if (!started && !lb_rd_valid && lb_data_out !== '0)
				report_mismatch("lb_data_out", 32'h0, lb_data_out);
			if (lb_rd_valid === 1'b1) begin
				if (exp_q.size() == 0) begin
					$display("lb_rd_valid went high at %0t ns with no read outstanding", $time);
					err_count++;
				end else begin
					exp_val = exp_q.pop_front();
					due = exp_due.pop_front();
					if (due != cyc) begin
						$display("lb_rd_valid at %0t ns came in cycle %0d instead of cycle %0d",
							$time, cyc, due);
						err_count++;
					end
					if (lb_data_out !== exp_val)
						report_mismatch("lb_data_out", exp_val, lb_data_out);
				end
			end else if (lb_rd_valid !== 1'b0) begin
				$display("lb_rd_valid is unknown at %0t ns", $time);
				err_count++;
			end
			// Decode edge sees writes and GPS samples up to the previous edge
			while (pend_cyc.size() > 0 && pend_cyc[0] == cyc) begin
				exp_val = predict_read(pend_addr[0]);
				if (pend_ee[0] && exp_val !== pend_exp[0]) begin
					$display("model value %h for address %h disagrees with table value %h",
						exp_val, pend_addr[0], pend_exp[0]);
					err_count++;
				end
				exp_q.push_back(exp_val);
				// Core capture, shell register, then the sampling edge
				exp_due.push_back(cyc + 3);
				void'(pend_addr.pop_front());
				void'(pend_cyc.pop_front());
				void'(pend_ee.pop_front());
				void'(pend_exp.pop_front());
			end
			if (cmd_strobe && !cmd_rd && cmd_addr == lb_pkg::REG_SCRATCH)
				scratch_m = cmd_data;
			if (gps[0] && !gps0_prev)
				count_m = count_m + 32'd1;
			gps0_prev = gps[0];
			if (cmd_strobe && cmd_rd) begin
				pend_addr.push_back(cmd_addr);
				pend_cyc.push_back(cyc + lb_pkg::READ_PIPE_LEN - 1);
				pend_ee.push_back(exp_en);
				pend_exp.push_back(exp_data);
			end
			{h2_stb, h2_rd, h2_addr, h2_data} = {h1_stb, h1_rd, h1_addr, h1_data};
			{h1_stb, h1_rd, h1_addr, h1_data} = {cmd_strobe, cmd_rd, cmd_addr, cmd_data};
			cyc++;
		end
		outstanding = pend_cyc.size() + exp_q.size();
	end

endmodule

//--- test/lb_base_tb.sv
// Local-bus base testbench
// Applies a command table to the shell and models the external application
`timescale 1ns/1ps

module lb_base_tb;

	localparam int          TABLE_LEN   = 27;
	localparam logic [31:0] APP_PATTERN = 32'ha5c3_0ff0;
	localparam int          WATCHDOG_NS = (TABLE_LEN + 20) * 40;

	logic        lb_clk;
	logic        arst_n;
	logic        cmd_strobe;
	logic        cmd_rd;
	logic [23:0] cmd_addr;
	logic [31:0] cmd_data;
	logic [3:0]  gps;
	logic [31:0] lb_data_in;
	logic        exp_en;
	logic [31:0] exp_data;
	logic [23:0] lb_addr;
	logic        lb_strobe, lb_rd, lb_write, lb_rd_valid;
	logic [31:0] lb_data_out;
	int          err_count;
	int          outstanding;

	// Stimulus table
	logic        t_stb[TABLE_LEN];
	logic        t_rd[TABLE_LEN];
	logic [23:0] t_addr[TABLE_LEN];
	logic [31:0] t_data[TABLE_LEN];
	logic [3:0]  t_gps[TABLE_LEN];
	logic        t_ee[TABLE_LEN];
	logic [31:0] t_exp[TABLE_LEN];
	int          fill_idx;
	logic [3:0]  gps_now;

	lb_base_shell dut (
		.lb_clk(lb_clk), .arst_n(arst_n),
		.cmd_strobe(cmd_strobe), .cmd_rd(cmd_rd), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.gps(gps), .lb_data_in(lb_data_in),
		.lb_addr(lb_addr), .lb_strobe(lb_strobe), .lb_rd(lb_rd), .lb_write(lb_write),
		.lb_rd_valid(lb_rd_valid), .lb_data_out(lb_data_out)
	);

	lb_base_checker #(.APP_PATTERN(APP_PATTERN)) chk (
		.lb_clk(lb_clk), .arst_n(arst_n),
		.cmd_strobe(cmd_strobe), .cmd_rd(cmd_rd), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
		.gps(gps), .exp_en(exp_en), .exp_data(exp_data),
		.lb_addr(lb_addr), .lb_strobe(lb_strobe), .lb_rd(lb_rd), .lb_write(lb_write),
		.lb_rd_valid(lb_rd_valid), .lb_data_out(lb_data_out),
		.err_count(err_count), .outstanding(outstanding)
	);

	// External application answers from the top address
	assign lb_data_in = {8'h00, lb_addr} ^ APP_PATTERN;

	initial lb_clk = 1'b0;
	always #20 lb_clk = ~lb_clk;

	task automatic add_entry(input logic stb, input logic rd, input logic [23:0] addr,
			input logic [31:0] data, input logic ee, input logic [31:0] exp_v);
		t_stb[fill_idx]  = stb;
		t_rd[fill_idx]   = rd;
		t_addr[fill_idx] = addr;
		t_data[fill_idx] = data;
		t_gps[fill_idx]  = gps_now;
		t_ee[fill_idx]   = ee;
		t_exp[fill_idx]  = exp_v;
		fill_idx++;
	endtask

	task automatic build_table();
		logic [31:0] scratch_val;
		logic [31:0] scratch_new;
		logic [31:0] rnd;
		fill_idx = 0;
		rnd = $urandom;
		gps_now = {rnd[2:0], 1'b0};
		scratch_val = $urandom;
		scratch_new = $urandom;
		add_entry(0, 0, 24'h0, 32'h0, 0, 32'h0);
		add_entry(1, 1, lb_pkg::REG_ID, 32'h0, 1, lb_pkg::ID_WORD);
		add_entry(1, 1, 24'h000005, 32'h0, 1, 32'h0);
		add_entry(1, 0, lb_pkg::REG_SCRATCH, scratch_val, 0, 32'h0);
		add_entry(1, 1, lb_pkg::REG_SCRATCH, 32'h0, 1, scratch_val);
		// Three reads in flight at once
		add_entry(1, 1, lb_pkg::REG_SCRATCH, 32'h0, 1, scratch_val);
		add_entry(1, 1, lb_pkg::REG_ID, 32'h0, 1, lb_pkg::ID_WORD);
		add_entry(1, 1, 24'h00000f, 32'h0, 1, 32'h0);
		add_entry(1, 1, 24'h000123, 32'h0, 1, 32'h0000_0123 ^ APP_PATTERN);
		add_entry(1, 1, 24'habcdef, 32'h0, 1, 32'h00ab_cdef ^ APP_PATTERN);
		// Scratch write on the edge where the read three commands back returns
		add_entry(1, 0, lb_pkg::REG_SCRATCH, scratch_new, 0, 32'h0);
		// Identity is read-only
		add_entry(1, 0, lb_pkg::REG_ID, $urandom, 0, 32'h0);
		add_entry(1, 1, lb_pkg::REG_ID, 32'h0, 1, lb_pkg::ID_WORD);
		add_entry(1, 1, lb_pkg::REG_SCRATCH, 32'h0, 1, scratch_new);
		// Three rising edges on GPS line 0
		for (int k = 0; k < 6; k++) begin
			gps_now[0] = (k == 5) ? 1'b1 : ~k[0];
			add_entry(0, 0, 24'h0, 32'h0, 0, 32'h0);
		end
		add_entry(1, 1, lb_pkg::REG_GPS_COUNT, 32'h0, 1, 32'd3);
		add_entry(1, 1, lb_pkg::REG_GPS_LEVEL, 32'h0, 1, {28'h0, gps_now});
		// Random external reads as filler
		for (int k = 0; k < 4; k++) begin
			rnd = $urandom;
			rnd[31:24] = 8'h00;
			rnd[8] = 1'b1;
			add_entry(1, 1, rnd[23:0], 32'h0, 1, rnd ^ APP_PATTERN);
		end
		add_entry(0, 0, 24'h0, 32'h0, 0, 32'h0);
	endtask

	// Main sequence
	initial begin
		void'($urandom(32'hde87));
		arst_n = 1'b0;
		cmd_strobe = 1'b0;
		cmd_rd = 1'b0;
		cmd_addr = '0;
		cmd_data = '0;
		gps = '0;
		exp_en = 1'b0;
		exp_data = '0;
		build_table();
		repeat (4) @(posedge lb_clk);
		#2 arst_n = 1'b1;
		for (int i = 0; i < TABLE_LEN; i++) begin
			@(posedge lb_clk);
			#2;
			cmd_strobe = t_stb[i];
			cmd_rd     = t_rd[i];
			cmd_addr   = t_addr[i];
			cmd_data   = t_data[i];
			gps        = t_gps[i];
			exp_en     = t_ee[i];
			exp_data   = t_exp[i];
		end
		@(posedge lb_clk);
		#2;
		cmd_strobe = 1'b0;
		exp_en = 1'b0;
		wait (outstanding == 0);
		repeat (3) @(posedge lb_clk);
		$display("Closing counts: %0d errors, %0d reads outstanding", err_count, outstanding);
		if (err_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired with %0d reads still outstanding", outstanding);
		$display("Done: errors found");
		$finish;
	end

endmodule
